// ==== design/isaPkg.sv ====
// instruction set package with field widths, field positions and encodings
`default_nettype none

package isaPkg;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // field widths
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        localparam int unsigned WordWidth    = 32;
        localparam int unsigned RegAddrWidth = 5;
        localparam int unsigned OpcodeWidth  = 6;
        localparam int unsigned FunctWidth   = 6;
        localparam int unsigned ShamtWidth   = 5;
        localparam int unsigned ImmWidth     = 16;

        localparam int unsigned NumRegs = 32;

        typedef logic [WordWidth-1:0]    word_t;
        typedef logic [RegAddrWidth-1:0] regAddr_t;
        typedef logic [OpcodeWidth-1:0]  opcode_t;
        typedef logic [FunctWidth-1:0]   funct_t;
        typedef logic [ShamtWidth-1:0]   shamt_t;
        typedef logic [ImmWidth-1:0]     imm16_t;

        // bit positions inside the instruction word
        localparam int unsigned OpcodeMsb = 31;
        localparam int unsigned OpcodeLsb = 26;
        localparam int unsigned RsMsb     = 25;
        localparam int unsigned RsLsb     = 21;
        localparam int unsigned RtMsb     = 20;
        localparam int unsigned RtLsb     = 16;
        localparam int unsigned RdMsb     = 15;
        localparam int unsigned RdLsb     = 11;
        localparam int unsigned ShamtMsb  = 10;
        localparam int unsigned ShamtLsb  = 6;
        localparam int unsigned FunctMsb  = 5;
        localparam int unsigned FunctLsb  = 0;
        localparam int unsigned ImmMsb    = 15;
        localparam int unsigned ImmLsb    = 0;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // opcodes
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        localparam opcode_t OpRType = 6'h00;
        localparam opcode_t OpJ     = 6'h02;
        localparam opcode_t OpBeq   = 6'h04;
        localparam opcode_t OpAddi  = 6'h08;
        localparam opcode_t OpAndi  = 6'h0c;
        localparam opcode_t OpOri   = 6'h0d;
        localparam opcode_t OpLui   = 6'h0f;
        localparam opcode_t OpLw    = 6'h23;
        localparam opcode_t OpSw    = 6'h2b;

        // R-type function codes, also the ALU function
        localparam funct_t FnSll  = 6'h00;
        localparam funct_t FnSrl  = 6'h02;
        localparam funct_t FnMult = 6'h18;
        localparam funct_t FnAdd  = 6'h20;
        localparam funct_t FnSub  = 6'h22;
        localparam funct_t FnAnd  = 6'h24;
        localparam funct_t FnOr   = 6'h25;
        localparam funct_t FnSlt  = 6'h2a;

endpackage

`default_nettype wire

// ==== design/ctrlPkg.sv ====
// control package with the decoded control bundle and immediate kinds
`default_nettype none

package ctrlPkg;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // immediate kinds
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        typedef logic [1:0] immKind_t;

        // sign extension is code zero so a bubble needs no special case
        localparam immKind_t ImmSign  = 2'd0;
        localparam immKind_t ImmZero  = 2'd1;
        localparam immKind_t ImmUpper = 2'd2;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // control bundle, 18 bits
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        typedef struct packed {
                logic          regDst;
                logic          branch;
                logic          jump;
                logic          memRead;
                logic          memtoReg;
                logic          aluOp;
                logic          mulOp;
                logic          memWrite;
                logic          aluSrc;
                logic          regWrite;
                immKind_t      immKind;
                isaPkg::funct_t aluFunc;
        } ctrl_t;

        // all zero bundle acts as a pipeline bubble
        localparam ctrl_t CtrlBubble = '0;

endpackage

`default_nettype wire

// ==== design/controlDecoder.sv ====
// control decoder turning opcode and function code into the control bundle
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
        input  isaPkg::opcode_t opcode,
        input  isaPkg::funct_t  funct,
        output ctrlPkg::ctrl_t  ctrl
);

        // function code is one of the supported R-type operations
        logic fnKnown;

        always_comb begin
                case (funct)
                        isaPkg::FnAdd,
                        isaPkg::FnSub,
                        isaPkg::FnAnd,
                        isaPkg::FnOr,
                        isaPkg::FnSlt,
                        isaPkg::FnSll,
                        isaPkg::FnSrl,
                        isaPkg::FnMult: fnKnown = 1'b1;
                        default:        fnKnown = 1'b0;
                endcase
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // main decode
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_comb begin
                ctrl = ctrlPkg::CtrlBubble;
                case (opcode)
                        isaPkg::OpRType: begin
                                if (fnKnown) begin
                                        ctrl.regDst   = 1'b1;
                                        ctrl.aluOp    = 1'b1;
                                        ctrl.regWrite = 1'b1;
                                        ctrl.mulOp    = (funct == isaPkg::FnMult);
                                        ctrl.immKind  = ctrlPkg::ImmSign;
                                        ctrl.aluFunc  = funct;
                                end
                        end
                        isaPkg::OpAddi, isaPkg::OpAndi, isaPkg::OpOri, isaPkg::OpLui: begin
                                ctrl.aluOp    = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                case (opcode)
                                        isaPkg::OpAndi: begin
                                                ctrl.immKind = ctrlPkg::ImmZero;
                                                ctrl.aluFunc = isaPkg::FnAnd;
                                        end
                                        isaPkg::OpOri: begin
                                                ctrl.immKind = ctrlPkg::ImmZero;
                                                ctrl.aluFunc = isaPkg::FnOr;
                                        end
                                        // lui ors the shifted immediate onto zero
                                        isaPkg::OpLui: begin
                                                ctrl.immKind = ctrlPkg::ImmUpper;
                                                ctrl.aluFunc = isaPkg::FnOr;
                                        end
                                        default: begin
                                                ctrl.immKind = ctrlPkg::ImmSign;
                                                ctrl.aluFunc = isaPkg::FnAdd;
                                        end
                                endcase
                        end
                        isaPkg::OpLw: begin
                                ctrl.aluOp    = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.memRead  = 1'b1;
                                ctrl.memtoReg = 1'b1;
                                ctrl.immKind  = ctrlPkg::ImmSign;
                                ctrl.aluFunc  = isaPkg::FnAdd;
                        end
                        isaPkg::OpSw: begin
                                ctrl.aluOp    = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.memWrite = 1'b1;
                                ctrl.immKind  = ctrlPkg::ImmSign;
                                ctrl.aluFunc  = isaPkg::FnAdd;
                        end
                        // compare by subtraction, zero result takes the branch
                        isaPkg::OpBeq: begin
                                ctrl.aluOp   = 1'b1;
                                ctrl.branch  = 1'b1;
                                ctrl.immKind = ctrlPkg::ImmSign;
                                ctrl.aluFunc = isaPkg::FnSub;
                        end
                        isaPkg::OpJ: begin
                                ctrl.jump = 1'b1;
                        end
                        default: begin
                                ctrl = ctrlPkg::CtrlBubble;
                        end
                endcase
        end

        // memory stage can do only one access per instruction
        always_comb begin
                memExclusive: assert final (!(ctrl.memRead && ctrl.memWrite))
                        else $error("memRead and memWrite both set, opcode %h", opcode);
                // plain j has no link register in this subset
                jumpNoWrite: assert final (!(ctrl.jump && ctrl.regWrite))
                        else $error("jump decoded with regWrite, opcode %h", opcode);
        end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
// register file, 32 words with two combinational reads and one clocked write
`timescale 1ns/10ps
`default_nettype none

module regFile (
        input  logic             Clock,
        input  logic             rst,
        input  logic             regWriteIn,
        input  isaPkg::regAddr_t wrAddr,
        input  isaPkg::word_t    wrData,
        input  isaPkg::regAddr_t rsAddr,
        input  isaPkg::regAddr_t rtAddr,
        output isaPkg::word_t    rsData,
        output isaPkg::word_t    rtData
);

        isaPkg::word_t regs [isaPkg::NumRegs];

        // register 0 is excluded from writes
        logic writeEn;

        assign writeEn = regWriteIn && (wrAddr != '0);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // write port
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_ff @(posedge Clock) begin
                if (rst) begin
                        for (int i = 0; i < isaPkg::NumRegs; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeEn) begin
                        regs[wrAddr] <= wrData;
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // read ports
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // no bypass, a same cycle write shows up after the edge
        assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
        assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

        // storage for r0 must survive any write, including one aimed at r0
        zeroRegHeld: assert property (
                @(posedge Clock) disable iff (rst)
                regWriteIn |=> (regs[0] == '0)
        ) else $error("register 0 changed after write to %0d", $past(wrAddr));

endmodule

`default_nettype wire

// ==== design/operandFormat.sv ====
// operand formatter for immediate, shift amount and destination register
`timescale 1ns/10ps
`default_nettype none

module operandFormat (
        input  isaPkg::imm16_t   imm16,
        input  isaPkg::regAddr_t rtAddr,
        input  isaPkg::regAddr_t rdAddr,
        input  isaPkg::shamt_t   shamtField,
        input  ctrlPkg::ctrl_t   ctrl,
        output isaPkg::word_t    immData,
        output isaPkg::shamt_t   shamt,
        output isaPkg::regAddr_t destAddr
);

        localparam int unsigned ExtWidth = isaPkg::WordWidth - isaPkg::ImmWidth;

        // shift instructions are the only users of the shamt field
        logic isShift;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // immediate
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_comb begin
                case (ctrl.immKind)
                        ctrlPkg::ImmZero:  immData = {{ExtWidth{1'b0}}, imm16};
                        ctrlPkg::ImmUpper: immData = {imm16, {ExtWidth{1'b0}}};
                        // unused code falls back to sign extension
                        default: begin
                                immData = {{ExtWidth{imm16[isaPkg::ImmWidth-1]}}, imm16};
                        end
                endcase
        end

        // R-type writes rd, everything else writes rt
        assign destAddr = ctrl.regDst ? rdAddr : rtAddr;

        assign isShift = ctrl.aluOp &&
                         ((ctrl.aluFunc == isaPkg::FnSll) || (ctrl.aluFunc == isaPkg::FnSrl));

        // zeroed for non-shifts so later stages never see a stray amount
        assign shamt = isShift ? shamtField : '0;

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
// decode stage top, slices the instruction and connects decoder, registers, formatter
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
        input  logic             Clock,
        input  logic             rst,
        input  isaPkg::word_t    instruction,
        input  logic             regWriteIn,
        input  isaPkg::regAddr_t wrAddr,
        input  isaPkg::word_t    wrData,
        output ctrlPkg::ctrl_t   ctrl,
        output isaPkg::word_t    rsData,
        output isaPkg::word_t    rtData,
        output isaPkg::word_t    immData,
        output isaPkg::shamt_t   shamt,
        output isaPkg::regAddr_t destAddr
);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // instruction fields
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        isaPkg::opcode_t  opcode;
        isaPkg::funct_t   funct;
        isaPkg::regAddr_t rsAddr;
        isaPkg::regAddr_t rtAddr;
        isaPkg::regAddr_t rdAddr;
        isaPkg::shamt_t   shamtField;
        isaPkg::imm16_t   imm16;

        assign opcode     = instruction[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb];
        assign rsAddr     = instruction[isaPkg::RsMsb:isaPkg::RsLsb];
        assign rtAddr     = instruction[isaPkg::RtMsb:isaPkg::RtLsb];
        assign rdAddr     = instruction[isaPkg::RdMsb:isaPkg::RdLsb];
        assign shamtField = instruction[isaPkg::ShamtMsb:isaPkg::ShamtLsb];
        assign funct      = instruction[isaPkg::FunctMsb:isaPkg::FunctLsb];
        assign imm16      = instruction[isaPkg::ImmMsb:isaPkg::ImmLsb];

        controlDecoder controlDecoder_inst (
                .opcode (opcode),
                .funct  (funct),
                .ctrl   (ctrl)
        );

        regFile regFile_inst (
                .Clock      (Clock),
                .rst        (rst),
                .regWriteIn (regWriteIn),
                .wrAddr     (wrAddr),
                .wrData     (wrData),
                .rsAddr     (rsAddr),
                .rtAddr     (rtAddr),
                .rsData     (rsData),
                .rtData     (rtData)
        );

        operandFormat operandFormat_inst (
                .imm16      (imm16),
                .rtAddr     (rtAddr),
                .rdAddr     (rdAddr),
                .shamtField (shamtField),
                .ctrl       (ctrl),
                .immData    (immData),
                .shamt      (shamt),
                .destAddr   (destAddr)
        );

endmodule

`default_nettype wire

// ==== include/decodeModel.svh ====
// reference model functions for the expected decode of an instruction
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// R-type with a function code from the supported list
function automatic bit isRType(isaPkg::word_t instr);
        isaPkg::funct_t fn;
        fn = instr[isaPkg::FunctMsb:isaPkg::FunctLsb];
        return (instr[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb] == isaPkg::OpRType) &&
               (fn inside {isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd, isaPkg::FnOr,
                           isaPkg::FnSlt, isaPkg::FnSll, isaPkg::FnSrl, isaPkg::FnMult});
endfunction

// control bits derived per instruction class
function automatic ctrlPkg::ctrl_t expCtrl(isaPkg::word_t instr);
        ctrlPkg::ctrl_t  c;
        isaPkg::opcode_t op;
        bit              rt;
        bit              isImm;
        op    = instr[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb];
        rt    = isRType(instr);
        isImm = op inside {isaPkg::OpAddi, isaPkg::OpAndi, isaPkg::OpOri,
                           isaPkg::OpLui, isaPkg::OpLw, isaPkg::OpSw};
        c          = '0;
        c.regDst   = rt;
        c.branch   = (op == isaPkg::OpBeq);
        c.jump     = (op == isaPkg::OpJ);
        c.memRead  = (op == isaPkg::OpLw);
        c.memtoReg = (op == isaPkg::OpLw);
        c.aluOp    = rt || isImm || (op == isaPkg::OpBeq);
        c.mulOp    = rt && (instr[isaPkg::FunctMsb:isaPkg::FunctLsb] == isaPkg::FnMult);
        c.memWrite = (op == isaPkg::OpSw);
        c.aluSrc   = isImm;
        c.regWrite = rt || (isImm && (op != isaPkg::OpSw));
        if (op inside {isaPkg::OpAndi, isaPkg::OpOri}) c.immKind = ctrlPkg::ImmZero;
        else if (op == isaPkg::OpLui) c.immKind = ctrlPkg::ImmUpper;
        else c.immKind = ctrlPkg::ImmSign;
        if (rt) c.aluFunc = instr[isaPkg::FunctMsb:isaPkg::FunctLsb];
        else if (op == isaPkg::OpAndi) c.aluFunc = isaPkg::FnAnd;
        else if (op inside {isaPkg::OpOri, isaPkg::OpLui}) c.aluFunc = isaPkg::FnOr;
        else if (op == isaPkg::OpBeq) c.aluFunc = isaPkg::FnSub;
        else if (isImm) c.aluFunc = isaPkg::FnAdd;
        return c;
endfunction

function automatic isaPkg::word_t expImm(isaPkg::word_t instr);
        isaPkg::opcode_t op;
        op = instr[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb];
        if (op inside {isaPkg::OpAndi, isaPkg::OpOri}) return {16'h0000, instr[15:0]};
        if (op == isaPkg::OpLui) return {instr[15:0], 16'h0000};
        return {{16{instr[15]}}, instr[15:0]};
endfunction

function automatic isaPkg::regAddr_t expDest(isaPkg::word_t instr);
        return isRType(instr) ? instr[isaPkg::RdMsb:isaPkg::RdLsb]
                              : instr[isaPkg::RtMsb:isaPkg::RtLsb];
endfunction

function automatic isaPkg::shamt_t expShamt(isaPkg::word_t instr);
        isaPkg::funct_t fn;
        fn = instr[isaPkg::FunctMsb:isaPkg::FunctLsb];
        if (isRType(instr) && (fn inside {isaPkg::FnSll, isaPkg::FnSrl}))
                return instr[isaPkg::ShamtMsb:isaPkg::ShamtLsb];
        return '0;
endfunction

`endif

// ==== bench/decodeStageTb.sv ====
// decode stage testbench with reference model, shadow register file and compare process
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;

        localparam int ResetTimeout   = 10;
        localparam int CompareTimeout = 4;

        localparam isaPkg::opcode_t ListedOps [9] = '{
                isaPkg::OpRType, isaPkg::OpAddi, isaPkg::OpAndi, isaPkg::OpOri, isaPkg::OpLui,
                isaPkg::OpLw, isaPkg::OpSw, isaPkg::OpBeq, isaPkg::OpJ
        };
        localparam isaPkg::funct_t ListedFns [8] = '{
                isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd, isaPkg::FnOr,
                isaPkg::FnSlt, isaPkg::FnSll, isaPkg::FnSrl, isaPkg::FnMult
        };

        logic             Clock = 1'b0;
        logic             rst;
        isaPkg::word_t    instruction;
        logic             regWriteIn;
        isaPkg::regAddr_t wrAddr;
        isaPkg::word_t    wrData;
        ctrlPkg::ctrl_t   ctrl;
        isaPkg::word_t    rsData;
        isaPkg::word_t    rtData;
        isaPkg::word_t    immData;
        isaPkg::shamt_t   shamt;
        isaPkg::regAddr_t destAddr;

        // expected register contents updated by the same strobe as the DUT
        isaPkg::word_t    shadow [isaPkg::NumRegs];
        integer           seed;
        int               compareCount;

        `include "decodeModel.svh"

        decodeStage decodeStage_inst (
                .Clock       (Clock),
                .rst         (rst),
                .instruction (instruction),
                .regWriteIn  (regWriteIn),
                .wrAddr      (wrAddr),
                .wrData      (wrData),
                .ctrl        (ctrl),
                .rsData      (rsData),
                .rtData      (rtData),
                .immData     (immData),
                .shamt       (shamt),
                .destAddr    (destAddr)
        );

        always #50 Clock = ~Clock;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // checking
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                               input string message);
                if (actual !== expected) begin
                        $display("FAIL at %0t ns: %s (got %h, expected %h)",
                                 $time, message, actual, expected);
                        $display("Some tests failed");
                        $fatal(1, "stopping at first mismatch");
                end
        endtask

        // reset wins over a write as in the register file
        always @(posedge Clock) begin
                if (rst) begin
                        for (int i = 0; i < isaPkg::NumRegs; i++) begin
                                shadow[i] <= '0;
                        end
                end else if (regWriteIn && (wrAddr != '0)) begin
                        shadow[wrAddr] <= wrData;
                end
        end

        // mid cycle when all combinational outputs have settled
        always @(negedge Clock) begin
                checkEq(32'(ctrl), 32'(expCtrl(instruction)),
                        $sformatf("control bundle for %h", instruction));
                checkEq(immData, expImm(instruction),
                        $sformatf("immediate for %h", instruction));
                checkEq(32'(shamt), 32'(expShamt(instruction)),
                        $sformatf("shift amount for %h", instruction));
                checkEq(32'(destAddr), 32'(expDest(instruction)),
                        $sformatf("destination register for %h", instruction));
                checkEq(rsData, shadow[instruction[isaPkg::RsMsb:isaPkg::RsLsb]],
                        $sformatf("rs read for %h", instruction));
                checkEq(rtData, shadow[instruction[isaPkg::RtMsb:isaPkg::RtLsb]],
                        $sformatf("rt read for %h", instruction));
                compareCount = compareCount + 1;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stimulus helpers
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        function automatic isaPkg::word_t randomListed();
                isaPkg::word_t instr;
                int unsigned   k;
                int unsigned   j;
                instr = $random(seed);
                k = $unsigned($random(seed)) % 9;
                j = $unsigned($random(seed)) % 8;
                instr[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb] = ListedOps[k];
                if (ListedOps[k] == isaPkg::OpRType) begin
                        instr[isaPkg::FunctMsb:isaPkg::FunctLsb] = ListedFns[j];
                end
                return instr;
        endfunction

        // unknown opcode or unlisted R-type function chosen at random
        function automatic isaPkg::word_t randomBubble();
                isaPkg::word_t   instr;
                isaPkg::word_t   pick;
                isaPkg::opcode_t op;
                isaPkg::funct_t  fn;
                instr = $random(seed);
                pick  = $random(seed);
                op    = instr[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb];
                fn    = instr[isaPkg::FunctMsb:isaPkg::FunctLsb];
                if (pick[0]) begin
                        if (op inside {isaPkg::OpRType, isaPkg::OpAddi, isaPkg::OpAndi,
                                       isaPkg::OpOri, isaPkg::OpLui, isaPkg::OpLw,
                                       isaPkg::OpSw, isaPkg::OpBeq, isaPkg::OpJ}) begin
                                op = 6'h3f;
                        end
                end else begin
                        op = isaPkg::OpRType;
                        if (fn inside {isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd, isaPkg::FnOr,
                                       isaPkg::FnSlt, isaPkg::FnSll, isaPkg::FnSrl,
                                       isaPkg::FnMult}) begin
                                fn = 6'h3f;
                        end
                end
                instr[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb] = op;
                instr[isaPkg::FunctMsb:isaPkg::FunctLsb]   = fn;
                return instr;
        endfunction

        // add with chosen source registers and random rd and shamt
        function automatic isaPkg::word_t readInstr(isaPkg::regAddr_t rsA, isaPkg::regAddr_t rtA);
                isaPkg::word_t instr;
                instr = $random(seed);
                instr[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb] = isaPkg::OpRType;
                instr[isaPkg::RsMsb:isaPkg::RsLsb]         = rsA;
                instr[isaPkg::RtMsb:isaPkg::RtLsb]         = rtA;
                instr[isaPkg::FunctMsb:isaPkg::FunctLsb]   = isaPkg::FnAdd;
                return instr;
        endfunction

        task automatic driveCycle(input isaPkg::word_t instr, input logic we,
                                  input isaPkg::regAddr_t addr, input isaPkg::word_t data);
                instruction <= instr;
                regWriteIn  <= we;
                wrAddr      <= addr;
                wrData      <= data;
                @(posedge Clock);
        endtask

        task automatic waitResetRelease();
                int cycles;
                cycles = 0;
                while ((rst !== 1'b0) && (cycles < ResetTimeout)) begin
                        @(posedge Clock);
                        cycles++;
                end
                if (rst !== 1'b0) begin
                        $display("timeout: reset was not released within %0d cycles",
                                 ResetTimeout);
                        $display("Some tests failed");
                        $fatal(1, "reset wait expired");
                end
        endtask

        task automatic waitCompare();
                int cycles;
                int target;
                cycles = 0;
                target = compareCount + 1;
                while ((compareCount < target) && (cycles < CompareTimeout)) begin
                        @(posedge Clock);
                        cycles++;
                end
                if (compareCount < target) begin
                        $display("timeout: compare process ran no check within %0d cycles",
                                 CompareTimeout);
                        $display("Some tests failed");
                        $fatal(1, "compare wait expired");
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // test sequence
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        initial begin
                int               n;
                isaPkg::regAddr_t a;
                isaPkg::regAddr_t lastA;
                isaPkg::word_t    d;
                seed         = 32'he538;
                compareCount = 0;
                rst          = 1'b1;
                instruction  = '0;
                regWriteIn   = 1'b0;
                wrAddr       = '0;
                wrData       = '0;
                lastA        = '0;
                for (n = 0; n < isaPkg::NumRegs; n++) begin
                        shadow[n] = '0;
                end
                repeat (3) @(posedge Clock);
                rst <= 1'b0;
                waitResetRelease();

                // every register reads zero after reset
                for (n = 0; n < isaPkg::NumRegs; n++) begin
                        driveCycle(readInstr(5'(n), 5'(31 - n)), 1'b0, '0, '0);
                end

                for (n = 0; n < 300; n++) begin
                        driveCycle(randomListed(), 1'b0, '0, '0);
                end
                for (n = 0; n < 100; n++) begin
                        driveCycle(randomBubble(), 1'b0, '0, '0);
                end

                // random writes with every eighth one aimed at r0
                for (n = 0; n < 300; n++) begin
                        a = 5'($random(seed));
                        d = $random(seed);
                        if ((n % 8) == 0) begin
                                a = '0;
                        end
                        driveCycle(readInstr(lastA, a), (n % 4) != 3, a, d);
                        lastA = a;
                end
                for (n = 0; n < isaPkg::NumRegs; n++) begin
                        driveCycle(readInstr(5'(n), 5'(n)), 1'b0, '0, '0);
                end

                // read of the address under write shows old data and then new
                for (n = 0; n < 20; n++) begin
                        a = 5'($random(seed));
                        if (a == '0) begin
                                a = 5'd1;
                        end
                        d = $random(seed);
                        driveCycle(readInstr(a, a), 1'b1, a, d);
                        driveCycle(readInstr(a, a), 1'b0, '0, '0);
                end

                // mid-run reset with write attempts and live decode
                rst <= 1'b1;
                for (n = 0; n < 3; n++) begin
                        driveCycle(randomListed(), 1'b1, 5'($random(seed)), $random(seed));
                end
                rst        <= 1'b0;
                regWriteIn <= 1'b0;
                waitResetRelease();
                for (n = 0; n < isaPkg::NumRegs; n++) begin
                        driveCycle(readInstr(5'(n), 5'(31 - n)), 1'b0, '0, '0);
                end

                waitCompare();
                $display("All tests passed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/isaPkg.sv
design/ctrlPkg.sv
design/controlDecoder.sv
design/regFile.sv
design/operandFormat.sv
design/decodeStage.sv
bench/decodeStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -f files.f --top-module decodeStageTb -o decodeStageTb

# a failing run exits non-zero, the log decides the result
./obj_dir/decodeStageTb > sim.log 2>&1 || true

cat sim.log

if grep -q "Some tests failed" sim.log; then
        echo "simulation reported failure"
        exit 1
fi

if ! grep -q "All tests passed" sim.log; then
        echo "simulation ended without a result"
        exit 1
fi

echo "simulation passed"
